// File: filelist.f
src/decode_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/operand_bypass.sv
src/branch_unit.sv
src/decode_stage.sv
test/decode_assertions.sv
test/decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= decode_stage_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb
  import decode_pkg::*;
;

  localparam int N_DECODE = 60;
  localparam int N_BRANCH = 30;
  // rough cycle count of all tests
  localparam int CYCLE_BUDGET = 8 + 48 + 20 + N_DECODE * 2 + N_BRANCH * 4 + 60;

  typedef struct packed {
    logic       wr;
    logic       s1pc;
    logic       s2imm;
    logic [4:0] rd;
    word_t      imm;
    logic [3:0] alu;
    logic [1:0] wb;
    logic [2:0] ld;
    logic [1:0] st;
    word_t      a;
    word_t      b;
    logic       redir;
    word_t      tgt;
  } exp_t;

  logic clk = 1'b0;
  logic rst;
  logic in_valid, in_ready, out_valid, out_ready;
  word_t in_pc, in_inst, out_pc, out_imm, out_rs1_value, out_rs2_value;
  logic out_src1_is_pc, out_src2_is_imm, out_rf_wr_en;
  reg_addr_t out_rf_waddr;
  wb_sel_t out_wb_sel;
  alu_op_t out_alu_op;
  load_op_t out_load_op;
  store_op_t out_store_op;
  logic exe_valid, exe_is_load, exe_wr_en, mem_valid, mem_wr_en, wb_valid, wb_wr_en;
  reg_addr_t exe_waddr, mem_waddr, wb_waddr;
  word_t exe_wdata, mem_wdata, wb_wdata;
  logic redirect_valid;
  word_t redirect_target;

  word_t model [32];
  word_t q_pc [$];
  word_t q_inst [$];
  string q_name [$];
  string cur_test = "reset";
  int errors = 0;
  int checks = 0;
  word_t rng_state = 32'd22;
  logic [2:0] load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
  logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  always #50 clk = ~clk;

  decode_stage u_decode_stage (.*);

  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // newest writer first, then the register model
  function automatic word_t operand(input logic [4:0] r);
    if (r == 5'd0)
      return '0;
    if (exe_valid && exe_wr_en && exe_waddr == r)
      return exe_wdata;
    if (mem_valid && mem_wr_en && mem_waddr == r)
      return mem_wdata;
    if (wb_valid && wb_wr_en && wb_waddr == r)
      return wb_wdata;
    return model[r];
  endfunction

  function automatic logic [3:0] alu_of(input logic [2:0] f3, input logic b30,
                                        input logic reg_form);
    case (f3)
      3'd0: return (reg_form && b30) ? ALU_SUB : ALU_ADD;
      3'd1: return ALU_SLL;
      3'd2: return ALU_SLT;
      3'd3: return ALU_SLTU;
      3'd4: return ALU_XOR;
      3'd5: return b30 ? ALU_SRA : ALU_SRL;
      3'd6: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // expected stage outputs for one instruction
  function automatic exp_t expect_of(input word_t inst, input word_t pc);
    exp_t e;
    logic [2:0] f3;
    word_t ii, is, ib, iu, ij;
    e = '0;
    e.alu = ALU_NONE;
    f3 = inst[14:12];
    ii = {{20{inst[31]}}, inst[31:20]};
    is = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    ib = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    iu = {inst[31:12], 12'd0};
    ij = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    e.rd = inst[11:7];
    e.a = operand(inst[19:15]);
    e.b = operand(inst[24:20]);
    case (inst[6:0])
      OP_LUI, OP_AUIPC:
      begin
        {e.wr, e.s1pc, e.s2imm, e.imm, e.wb} = {3'b111, iu, WB_ALU};
        e.alu = (inst[6:0] == OP_LUI) ? ALU_LUI : ALU_ADD;
      end
      OP_JAL:
      begin
        {e.wr, e.s1pc, e.s2imm, e.imm, e.alu, e.wb} = {3'b111, ij, ALU_ADD, WB_PC_PLUS4};
        {e.redir, e.tgt} = {1'b1, pc + ij};
      end
      OP_JALR:
      begin
        {e.wr, e.s2imm, e.imm, e.alu, e.wb} = {2'b11, ii, ALU_ADD, WB_PC_PLUS4};
        {e.redir, e.tgt} = {1'b1, e.a + ii};
      end
      OP_BRANCH:
      begin
        {e.s1pc, e.s2imm, e.imm, e.alu, e.tgt} = {2'b11, ib, ALU_ADD, pc + ib};
        case (f3)
          3'd0: e.redir = (e.a == e.b);
          3'd1: e.redir = (e.a != e.b);
          3'd4: e.redir = ($signed(e.a) < $signed(e.b));
          3'd5: e.redir = ($signed(e.a) >= $signed(e.b));
          3'd6: e.redir = (e.a < e.b);
          default: e.redir = (e.a >= e.b);
        endcase
      end
      OP_LOAD:
      begin
        {e.wr, e.s2imm, e.imm, e.alu, e.wb} = {2'b11, ii, ALU_ADD, WB_MEM};
        e.ld = (f3 == 3'd0) ? LD_LB : (f3 == 3'd1) ? LD_LH : (f3 == 3'd2) ? LD_LW :
               (f3 == 3'd4) ? LD_LBU : LD_LHU;
      end
      OP_STORE:
      begin
        {e.s2imm, e.imm, e.alu} = {1'b1, is, ALU_ADD};
        e.st = (f3 == 3'd0) ? ST_SB : (f3 == 3'd1) ? ST_SH : ST_SW;
      end
      OP_ALU_IMM:
      begin
        {e.wr, e.s2imm, e.imm, e.wb} = {2'b11, ii, WB_ALU};
        e.alu = alu_of(f3, inst[30], 1'b0);
      end
      default:
      begin
        {e.wr, e.wb} = {1'b1, WB_ALU};
        e.alu = alu_of(f3, inst[30], 1'b1);
      end
    endcase
    e.wr = e.wr && (e.rd != 5'd0);
    return e;
  endfunction

  // legal random instruction of one format
  function automatic word_t rand_inst(input int kind);
    word_t r;
    r = next_rand();
    case (kind)
      0:
      begin
        r[6:0] = OP_ALU_IMM;
        if (r[14:12] == 3'd1)
          r[31:25] = 7'd0;
        else if (r[14:12] == 3'd5)
          r[31:25] = {1'b0, r[30], 5'd0};
      end
      1:
      begin
        r[6:0] = OP_ALU;
        r[31:25] = (r[14:12] == 3'd0 || r[14:12] == 3'd5) ? {1'b0, r[30], 5'd0} : 7'd0;
      end
      2: r[6:0] = OP_LUI;
      3: r[6:0] = OP_AUIPC;
      4:
      begin
        r[6:0] = OP_LOAD;
        r[14:12] = load_f3[int'(next_rand() % 5)];
      end
      5:
      begin
        r[6:0] = OP_STORE;
        r[14:12] = 3'(next_rand() % 3);
      end
      6:
      begin
        r[6:0] = OP_BRANCH;
        r[14:12] = br_f3[int'(next_rand() % 6)];
        // equal operands for half of the branches
        if (r[31])
          r[24:20] = r[19:15];
      end
      7: r[6:0] = OP_JAL;
      default:
      begin
        r[6:0] = OP_JALR;
        r[14:12] = 3'd0;
      end
    endcase
    return r;
  endfunction

  task automatic check_field(input string test, input string field, input word_t exp,
                             input word_t act);
    checks++;
    assert (exp == act)
    else
    begin
      $display("ERROR %s %s: expected %h, actual %h", test, field, exp, act);
      errors++;
    end
  endtask

  always @(posedge clk)
  begin : compare
    exp_t e;
    string name;
    if (!rst)
    begin
      if (out_valid && out_ready)
      begin
        assert (q_inst.size() != 0)
        else
        begin
          $display("an instruction at pc %h left decode with none pending", out_pc);
          errors++;
        end
        if (q_inst.size() != 0)
        begin
          e = expect_of(q_inst[0], q_pc[0]);
          name = q_name.pop_front();
          check_field(name, "pc", q_pc.pop_front(), out_pc);
          void'(q_inst.pop_front());
          check_field(name, "rf_wr_en", 32'(e.wr), 32'(out_rf_wr_en));
          check_field(name, "src1_is_pc", 32'(e.s1pc), 32'(out_src1_is_pc));
          check_field(name, "src2_is_imm", 32'(e.s2imm), 32'(out_src2_is_imm));
          check_field(name, "rf_waddr", 32'(e.rd), 32'(out_rf_waddr));
          check_field(name, "imm", e.imm, out_imm);
          check_field(name, "alu_op", 32'(e.alu), 32'(out_alu_op));
          check_field(name, "wb_sel", 32'(e.wb), 32'(out_wb_sel));
          check_field(name, "load_op", 32'(e.ld), 32'(out_load_op));
          check_field(name, "store_op", 32'(e.st), 32'(out_store_op));
          check_field(name, "rs1_value", e.a, out_rs1_value);
          check_field(name, "rs2_value", e.b, out_rs2_value);
          check_field(name, "redirect_valid", 32'(e.redir), 32'(redirect_valid));
          if (e.redir)
            check_field(name, "redirect_target", e.tgt, redirect_target);
        end
      end
      // fetch slot in a redirect cycle is dropped
      if (in_valid && in_ready && !redirect_valid)
      begin
        q_pc.push_back(in_pc);
        q_inst.push_back(in_inst);
        q_name.push_back(cur_test);
      end
      if (wb_valid && wb_wr_en && wb_waddr != 5'd0)
        model[wb_waddr] = wb_wdata;
    end
  end

  task automatic send(input word_t pc, input word_t inst);
    @(negedge clk);
    in_valid = 1'b1;
    in_pc = pc;
    in_inst = inst;
    do
      @(posedge clk);
    while (!in_ready);
  endtask

  task automatic drain();
    @(negedge clk);
    in_valid = 1'b0;
    while (q_inst.size() != 0)
      @(negedge clk);
  endtask

  task automatic expect_hold(input string what, input logic cond);
    checks++;
    assert (cond)
    else
    begin
      $display("%s went wrong at time %0t", what, $time);
      errors++;
    end
  endtask

  initial
  begin : watchdog
    #(CYCLE_BUDGET * 100);
    $display("timeout: the tests did not finish in %0d cycles", CYCLE_BUDGET);
    $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin : stimulus
    word_t pc;
    word_t snap;
    for (int i = 0; i < 32; i++)
      model[i] = '0;
    {in_valid, in_pc, in_inst, out_ready} = {1'b0, 32'd0, 32'd0, 1'b1};
    {exe_valid, exe_is_load, exe_wr_en, exe_waddr, exe_wdata} = '0;
    {mem_valid, mem_wr_en, mem_waddr, mem_wdata} = '0;
    {wb_valid, wb_wr_en, wb_waddr, wb_wdata} = '0;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    expect_hold("reset state", in_ready && !out_valid && !redirect_valid && !out_rf_wr_en);
    pc = 32'h1000;

    cur_test = "regfile";
    for (int r = 0; r < 32; r++)
    begin
      @(negedge clk);
      {wb_valid, wb_wr_en, wb_waddr, wb_wdata} = {2'b11, 5'(r), next_rand()};
    end
    @(negedge clk);
    wb_valid = 1'b0;
    send(pc, {7'd0, 5'd0, 5'd0, 3'd0, 5'd0, OP_ALU});
    for (int i = 0; i < 8; i++)
    begin
      pc += 4;
      send(pc, rand_inst(1));
    end
    drain();

    cur_test = "decode";
    for (int i = 0; i < N_DECODE; i++)
    begin
      pc += 4;
      send(pc, rand_inst(int'(next_rand() % 6)));
    end
    drain();

    cur_test = "forward";
    @(negedge clk);
    {exe_valid, exe_wr_en, exe_waddr, exe_wdata} = {2'b11, 5'd7, next_rand()};
    {mem_valid, mem_wr_en, mem_waddr, mem_wdata} = {2'b11, 5'd7, next_rand()};
    {wb_valid, wb_wr_en, wb_waddr, wb_wdata} = {2'b11, 5'd7, next_rand()};
    for (int step = 0; step < 4; step++)
    begin
      pc += 4;
      send(pc, {7'd0, 5'd7, 5'd7, 3'd0, 5'd8, OP_ALU});
      if (step == 2)
      begin
        // a fresh wb value in the leave cycle is not yet in the register file
        @(negedge clk);
        in_valid = 1'b0;
        wb_wdata = next_rand();
      end
      drain();
      case (step)
        0: exe_valid = 1'b0;
        1: mem_wr_en = 1'b0;
        default:
        begin
          // new data on an invalid wb writer must not reach the operand
          wb_valid = 1'b0;
          wb_wdata = next_rand();
        end
      endcase
    end

    cur_test = "load_use";
    @(negedge clk);
    {exe_valid, exe_is_load, exe_wr_en, exe_waddr, exe_wdata} = {3'b111, 5'd9, next_rand()};
    pc += 4;
    send(pc, {12'h123, 5'd9, 3'd0, 5'd10, OP_ALU_IMM});
    @(negedge clk);
    in_valid = 1'b0;
    repeat (3)
    begin
      @(posedge clk);
      expect_hold("load-use stall", !out_valid && !in_ready);
    end
    @(negedge clk);
    exe_is_load = 1'b0;
    drain();
    exe_valid = 1'b0;

    cur_test = "branch";
    for (int i = 0; i < N_BRANCH; i++)
    begin
      pc += 4;
      send(pc, rand_inst(6 + int'(next_rand() % 3)));
      drain();
    end
    pc += 4;
    send(pc, rand_inst(7));
    @(negedge clk);
    {in_pc, in_inst} = {pc + 32'd4, {12'd1, 5'd0, 3'd0, 5'd31, OP_ALU_IMM}};
    @(posedge clk);
    expect_hold("redirect on jal", redirect_valid);
    drain();

    cur_test = "backpressure";
    @(negedge clk);
    out_ready = 1'b0;
    pc += 4;
    send(pc, rand_inst(7));
    @(negedge clk);
    in_valid = 1'b0;
    @(posedge clk);
    snap = out_imm;
    repeat (3)
    begin
      @(posedge clk);
      expect_hold("back-pressure hold",
                  out_valid && !in_ready && !redirect_valid && out_imm == snap && out_pc == pc);
    end
    @(negedge clk);
    out_ready = 1'b1;
    drain();
    repeat (2) @(negedge clk);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: test/decode_assertions.sv
`timescale 1ns/1ps

module decode_assertions
  import decode_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      out_valid,
  input logic      out_ready,
  input logic      redirect_valid,
  input word_t     out_pc,
  input word_t     out_imm,
  input reg_addr_t out_rf_waddr,
  input logic      out_rf_wr_en,
  input wb_sel_t   out_wb_sel,
  input store_op_t out_store_op
);

  // stalled output keeps its fields
  assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> $stable({out_pc, out_imm, out_rf_waddr, out_rf_wr_en}))
  else $error("decode outputs changed under back-pressure");

  // only a branch or a jump redirects fetch
  assert property (@(posedge clk) disable iff (rst)
    redirect_valid |-> (out_wb_sel == WB_NONE || out_wb_sel == WB_PC_PLUS4)
                       && (out_store_op == ST_NONE))
  else $error("redirect from an instruction that is not a branch or jump");

  // the wrong-path slot is dropped, so decode is empty next cycle
  assert property (@(posedge clk) disable iff (rst) redirect_valid |=> !out_valid)
  else $error("decode still valid after a redirect");

endmodule

bind decode_stage decode_assertions u_decode_assertions (
  .clk            (clk),
  .rst            (rst),
  .out_valid      (out_valid),
  .out_ready      (out_ready),
  .redirect_valid (redirect_valid),
  .out_pc         (out_pc),
  .out_imm        (out_imm),
  .out_rf_waddr   (out_rf_waddr),
  .out_rf_wr_en   (out_rf_wr_en),
  .out_wb_sel     (out_wb_sel),
  .out_store_op   (out_store_op)
);

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import decode_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  output logic            in_ready,
  input  word_t           in_pc,
  input  logic [ILEN-1:0] in_inst,
  output logic            out_valid,
  input  logic            out_ready,
  output word_t           out_pc,
  output word_t           out_imm,
  output word_t           out_rs1_value,
  output word_t           out_rs2_value,
  output logic            out_src1_is_pc,
  output logic            out_src2_is_imm,
  output logic            out_rf_wr_en,
  output reg_addr_t       out_rf_waddr,
  output wb_sel_t         out_wb_sel,
  output alu_op_t         out_alu_op,
  output load_op_t        out_load_op,
  output store_op_t       out_store_op,
  input  logic            exe_valid,
  input  logic            exe_is_load,
  input  logic            exe_wr_en,
  input  reg_addr_t       exe_waddr,
  input  word_t           exe_wdata,
  input  logic            mem_valid,
  input  logic            mem_wr_en,
  input  reg_addr_t       mem_waddr,
  input  word_t           mem_wdata,
  input  logic            wb_valid,
  input  logic            wb_wr_en,
  input  reg_addr_t       wb_waddr,
  input  word_t           wb_wdata,
  output logic            redirect_valid,
  output word_t           redirect_target
);

  // decode register
  logic            id_valid;
  word_t           id_pc;
  logic [ILEN-1:0] id_inst;

  logic      dec_rf_wr_en;
  logic      use_rs1;
  logic      use_rs2;
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  logic      load_use_stall;
  logic      taken;

  assign out_valid = id_valid && !load_use_stall;
  assign in_ready  = !id_valid || (out_valid && out_ready);

  // only resolve when the instruction actually leaves this cycle
  assign redirect_valid = out_valid && out_ready && taken;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      id_valid <= 1'b0;
    end
    else if (redirect_valid)
    begin
      // the fetch slot behind a taken jump is on the wrong path
      id_valid <= 1'b0;
    end
    else if (in_ready)
    begin
      id_valid <= in_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
    begin
      id_pc   <= in_pc;
      id_inst <= in_inst;
    end
  end

  inst_decoder u_inst_decoder (
    .inst        (id_inst),
    .rf_wr_en    (dec_rf_wr_en),
    .src1_is_pc  (out_src1_is_pc),
    .src2_is_imm (out_src2_is_imm),
    .use_rs1     (use_rs1),
    .use_rs2     (use_rs2),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (out_rf_waddr),
    .imm         (out_imm),
    .alu_op      (out_alu_op),
    .wb_sel      (out_wb_sel),
    .load_op     (out_load_op),
    .store_op    (out_store_op)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .we     (wb_valid && wb_wr_en),
    .waddr  (wb_waddr),
    .wdata  (wb_wdata)
  );

  operand_bypass u_operand_bypass (
    .rs1            (rs1),
    .rs2            (rs2),
    .exe_waddr      (exe_waddr),
    .mem_waddr      (mem_waddr),
    .wb_waddr       (wb_waddr),
    .use_rs1        (use_rs1),
    .use_rs2        (use_rs2),
    .exe_valid      (exe_valid),
    .exe_is_load    (exe_is_load),
    .exe_wr_en      (exe_wr_en),
    .mem_valid      (mem_valid),
    .mem_wr_en      (mem_wr_en),
    .wb_valid       (wb_valid),
    .wb_wr_en       (wb_wr_en),
    .rf_rdata1      (rf_rdata1),
    .rf_rdata2      (rf_rdata2),
    .exe_wdata      (exe_wdata),
    .mem_wdata      (mem_wdata),
    .wb_wdata       (wb_wdata),
    .rs1_value      (out_rs1_value),
    .rs2_value      (out_rs2_value),
    .load_use_stall (load_use_stall)
  );

  branch_unit u_branch_unit (
    .pc        (id_pc),
    .imm       (out_imm),
    .rs1_value (out_rs1_value),
    .rs2_value (out_rs2_value),
    .funct3    (id_inst[14:12]),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .taken     (taken),
    .target    (redirect_target)
  );

  assign out_pc       = id_pc;
  assign out_rf_wr_en = id_valid && dec_rf_wr_en;

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
  import decode_pkg::*;
(
  input  word_t      pc,
  input  word_t      imm,
  input  word_t      rs1_value,
  input  word_t      rs2_value,
  input  logic [2:0] funct3,
  input  logic       is_branch,
  input  logic       is_jal,
  input  logic       is_jalr,
  output logic       taken,
  output word_t      target
);

  logic cond;

  always_comb
  begin
    case (funct3)
      3'b000: cond = (rs1_value == rs2_value);
      3'b001: cond = (rs1_value != rs2_value);
      3'b100: cond = ($signed(rs1_value) < $signed(rs2_value));
      3'b101: cond = ($signed(rs1_value) >= $signed(rs2_value));
      3'b110: cond = (rs1_value < rs2_value);
      3'b111: cond = (rs1_value >= rs2_value);
      default: cond = 1'b0;
    endcase
  end

  // jumps are always taken
  assign taken = is_jal || is_jalr || (is_branch && cond);

  // jalr is register relative, everything else pc relative
  assign target = is_jalr ? (rs1_value + imm) : (pc + imm);

endmodule

// File: src/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass
  import decode_pkg::*;
(
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t exe_waddr,
  input  reg_addr_t mem_waddr,
  input  reg_addr_t wb_waddr,
  input  logic      use_rs1,
  input  logic      use_rs2,
  input  logic      exe_valid,
  input  logic      exe_is_load,
  input  logic      exe_wr_en,
  input  logic      mem_valid,
  input  logic      mem_wr_en,
  input  logic      wb_valid,
  input  logic      wb_wr_en,
  input  word_t     rf_rdata1,
  input  word_t     rf_rdata2,
  input  word_t     exe_wdata,
  input  word_t     mem_wdata,
  input  word_t     wb_wdata,
  output word_t     rs1_value,
  output word_t     rs2_value,
  output logic      load_use_stall
);

  logic exe_writes;
  logic mem_writes;
  logic wb_writes;
  logic exe_hit1;
  logic exe_hit2;

  // a writer to x0 never matches, x0 stays zero
  assign exe_writes = exe_valid && exe_wr_en && (exe_waddr != 5'd0);
  assign mem_writes = mem_valid && mem_wr_en && (mem_waddr != 5'd0);
  assign wb_writes  = wb_valid && wb_wr_en && (wb_waddr != 5'd0);

  assign exe_hit1 = exe_writes && (rs1 == exe_waddr);
  assign exe_hit2 = exe_writes && (rs2 == exe_waddr);

  // newest writer wins
  assign rs1_value = exe_hit1                            ? exe_wdata :
                     (mem_writes && (rs1 == mem_waddr)) ? mem_wdata :
                     (wb_writes && (rs1 == wb_waddr))   ? wb_wdata  :
                     rf_rdata1;

  assign rs2_value = exe_hit2                            ? exe_wdata :
                     (mem_writes && (rs2 == mem_waddr)) ? mem_wdata :
                     (wb_writes && (rs2 == wb_waddr))   ? wb_wdata  :
                     rf_rdata2;

  // load data is not ready until memory, so hold the consumer
  assign load_use_stall = exe_is_load && ((use_rs1 && exe_hit1) || (use_rs2 && exe_hit2));

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file
  import decode_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t regs [32];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we && (waddr != 5'd0))
    begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, same-cycle writes come through the wb forward path
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
  import decode_pkg::*;
(
  input  word_t     inst,
  output logic      rf_wr_en,
  output logic      src1_is_pc,
  output logic      src2_is_imm,
  output logic      use_rs1,
  output logic      use_rs2,
  output logic      is_branch,
  output logic      is_jal,
  output logic      is_jalr,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output alu_op_t   alu_op,
  output wb_sel_t   wb_sel,
  output load_op_t  load_op,
  output store_op_t store_op
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       writes;
  alu_op_t    imm_alu;
  alu_op_t    reg_alu;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // alu op for reg-imm and reg-reg forms, ALU_NONE when funct bits are illegal
  always_comb
  begin
    imm_alu = ALU_NONE;
    reg_alu = ALU_NONE;
    case (funct3)
      3'b000: imm_alu = ALU_ADD;
      3'b010: imm_alu = ALU_SLT;
      3'b011: imm_alu = ALU_SLTU;
      3'b100: imm_alu = ALU_XOR;
      3'b110: imm_alu = ALU_OR;
      3'b111: imm_alu = ALU_AND;
      3'b001: imm_alu = (funct7 == 7'b0000000) ? ALU_SLL : ALU_NONE;
      default:
        imm_alu = (funct7 == 7'b0000000) ? ALU_SRL :
                  (funct7 == 7'b0100000) ? ALU_SRA : ALU_NONE;
    endcase
    if (funct7 == 7'b0000000)
    begin
      reg_alu = (funct3 == 3'b000) ? ALU_ADD : imm_alu;
    end
    else if (funct7 == 7'b0100000)
    begin
      reg_alu = (funct3 == 3'b000) ? ALU_SUB : (funct3 == 3'b101) ? ALU_SRA : ALU_NONE;
    end
  end

  always_comb
  begin
    writes      = 1'b0;
    src1_is_pc  = 1'b0;
    src2_is_imm = 1'b0;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    imm         = '0;
    alu_op      = ALU_NONE;
    wb_sel      = WB_NONE;
    load_op     = LD_NONE;
    store_op    = ST_NONE;
    case (opcode)
      OP_LUI, OP_AUIPC:
      begin
        writes      = 1'b1;
        src1_is_pc  = 1'b1;
        src2_is_imm = 1'b1;
        imm         = imm_u;
        alu_op      = (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
        wb_sel      = WB_ALU;
      end
      OP_JAL:
      begin
        writes      = 1'b1;
        src1_is_pc  = 1'b1;
        src2_is_imm = 1'b1;
        is_jal      = 1'b1;
        imm         = imm_j;
        alu_op      = ALU_ADD;
        wb_sel      = WB_PC_PLUS4;
      end
      OP_JALR:
      begin
        if (funct3 == 3'b000)
        begin
          writes      = 1'b1;
          src2_is_imm = 1'b1;
          use_rs1     = 1'b1;
          is_jalr     = 1'b1;
          imm         = imm_i;
          alu_op      = ALU_ADD;
          wb_sel      = WB_PC_PLUS4;
        end
      end
      OP_BRANCH:
      begin
        // funct3 010 and 011 are not branches
        if (funct3[2:1] != 2'b01)
        begin
          src1_is_pc  = 1'b1;
          src2_is_imm = 1'b1;
          use_rs1     = 1'b1;
          use_rs2     = 1'b1;
          is_branch   = 1'b1;
          imm         = imm_b;
          alu_op      = ALU_ADD;
        end
      end
      OP_LOAD:
      begin
        case (funct3)
          3'b000: load_op = LD_LB;
          3'b001: load_op = LD_LH;
          3'b010: load_op = LD_LW;
          3'b100: load_op = LD_LBU;
          3'b101: load_op = LD_LHU;
          default: load_op = LD_NONE;
        endcase
        if (load_op != LD_NONE)
        begin
          writes      = 1'b1;
          src2_is_imm = 1'b1;
          use_rs1     = 1'b1;
          imm         = imm_i;
          alu_op      = ALU_ADD;
          wb_sel      = WB_MEM;
        end
      end
      OP_STORE:
      begin
        case (funct3)
          3'b000: store_op = ST_SB;
          3'b001: store_op = ST_SH;
          3'b010: store_op = ST_SW;
          default: store_op = ST_NONE;
        endcase
        if (store_op != ST_NONE)
        begin
          src2_is_imm = 1'b1;
          use_rs1     = 1'b1;
          use_rs2     = 1'b1;
          imm         = imm_s;
          alu_op      = ALU_ADD;
        end
      end
      OP_ALU_IMM:
      begin
        if (imm_alu != ALU_NONE)
        begin
          writes      = 1'b1;
          src2_is_imm = 1'b1;
          use_rs1     = 1'b1;
          imm         = imm_i;
          alu_op      = imm_alu;
          wb_sel      = WB_ALU;
        end
      end
      OP_ALU:
      begin
        if (reg_alu != ALU_NONE)
        begin
          writes  = 1'b1;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
          alu_op  = reg_alu;
          wb_sel  = WB_ALU;
        end
      end
      default:
      begin
        writes = 1'b0;
      end
    endcase
  end

  // x0 is never written
  assign rf_wr_en = writes && (rd != 5'd0);

endmodule

// File: src/decode_pkg.sv
package decode_pkg;

  localparam int XLEN = 32;
  localparam int ILEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // operation requested from the execute stage ALU
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_LUI  = 4'd10,
    ALU_NONE = 4'd15
  } alu_op_t;

  // source of the value written back to rd
  typedef enum logic [1:0] {
    WB_NONE     = 2'd0,
    WB_PC_PLUS4 = 2'd1,
    WB_ALU      = 2'd2,
    WB_MEM      = 2'd3
  } wb_sel_t;

  typedef enum logic [2:0] {
    LD_NONE = 3'd0,
    LD_LB   = 3'd1,
    LD_LBU  = 3'd2,
    LD_LH   = 3'd3,
    LD_LHU  = 3'd4,
    LD_LW   = 3'd5
  } load_op_t;

  typedef enum logic [1:0] {
    ST_NONE = 2'd0,
    ST_SB   = 2'd1,
    ST_SH   = 2'd2,
    ST_SW   = 2'd3
  } store_op_t;

  // major opcodes of the RV32I base set
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_AUIPC   = 7'b0010111;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;
  localparam logic [6:0] OP_JAL     = 7'b1101111;
  localparam logic [6:0] OP_JALR    = 7'b1100111;
  localparam logic [6:0] OP_LOAD    = 7'b0000011;
  localparam logic [6:0] OP_STORE   = 7'b0100011;
  localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
  localparam logic [6:0] OP_ALU     = 7'b0110011;

endpackage
